/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // plain machine word: addresses, instructions and data.
    typedef logic [31:0] word_t;

    // one-hot exception cause vector.
    typedef logic [15:0] ecode_t;

    localparam int inst_mem_words = 1024;

    // word index into the instruction memory.
    typedef logic [$clog2(inst_mem_words)-1:0] mem_addr_t;

    localparam word_t reset_vector = 32'h1c00_0000;
    localparam word_t nop_inst     = 32'h0280_0000;  // addi.w r0, r0, 0.

    localparam logic [5:0] op_b  = 6'b010100;
    localparam logic [5:0] op_bl = 6'b010101;

    localparam ecode_t ecode_adef = 16'h4000;  // fetch address error, bit 14.

    // decode to fetch redirect.
    typedef struct packed {
        logic  taken;
        word_t target;
    } br_bus_t;

    typedef struct packed {
        word_t  pc;
        word_t  inst;
        logic   excp;
        ecode_t excp_num;
    } fs_to_ds_t;

    typedef struct packed {
        word_t  pc;
        word_t  inst;
        logic   excp;
        ecode_t excp_num;
        logic   is_jump;  // b or bl.
    } ds_to_es_t;

endpackage

`default_nettype wire

/* design/inst_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_sram (
    input  wire                     clk,
    input  wire                     en,
    input  wire cpu_pkg::word_t     addr,
    input  wire                     load_en,
    input  wire cpu_pkg::mem_addr_t load_addr,
    input  wire cpu_pkg::word_t     load_data,
    output cpu_pkg::word_t          rdata
);

    localparam int idx_bits = $bits(cpu_pkg::mem_addr_t);

    cpu_pkg::word_t    mem [cpu_pkg::inst_mem_words];
    cpu_pkg::mem_addr_t rd_idx;

    // byte address to word index.
    assign rd_idx = addr[idx_bits+1:2];

    // program preload, one word per cycle.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // read data holds while en is low.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

/* design/if_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module if_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     ds_allowin,
    input  wire cpu_pkg::br_bus_t   br_bus,
    input  wire                     excp_flush,
    input  wire                     ertn_flush,
    input  wire cpu_pkg::word_t     era,
    input  wire cpu_pkg::word_t     eentry,
    input  wire cpu_pkg::word_t     inst_sram_rdata,
    output logic                    fs_to_ds_valid,
    output cpu_pkg::fs_to_ds_t      fs_to_ds_bus,
    output logic                    inst_sram_en,
    output cpu_pkg::word_t          inst_sram_addr
);

    logic           flush;
    logic           fs_allowin;
    logic           fs_valid;
    logic           fs_adef;
    cpu_pkg::word_t fs_pc;
    cpu_pkg::word_t seq_pc;
    cpu_pkg::word_t nextpc;
    cpu_pkg::word_t fs_inst;

    assign flush = excp_flush | ertn_flush;

    // pre-if stage.
    assign seq_pc = fs_pc + 32'd4;

    always_comb begin
        if (excp_flush) begin
            nextpc = eentry;
        end else if (ertn_flush) begin
            nextpc = era;
        end else if (br_bus.taken) begin
            nextpc = br_bus.target;
        end else begin
            nextpc = seq_pc;
        end
    end

    // if stage.
    assign fs_allowin = !fs_valid || ds_allowin || flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= 1'b1;
        end
    end

    // adef is captured with the pc it belongs to.
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc   <= cpu_pkg::reset_vector - 32'd4;  // first request hits the vector.
            fs_adef <= 1'b0;
        end else if (fs_allowin) begin
            fs_pc   <= nextpc;
            fs_adef <= nextpc[1:0] != 2'b00;
        end
    end

    // a stalled stage issues no read, so rdata keeps its word.
    assign inst_sram_en   = fs_allowin;
    assign inst_sram_addr = nextpc;

    // the word behind a taken jump is wrong-path.
    assign fs_inst = br_bus.taken ? cpu_pkg::nop_inst : inst_sram_rdata;

    assign fs_to_ds_valid = fs_valid && !flush;

    assign fs_to_ds_bus.pc       = fs_pc;
    assign fs_to_ds_bus.inst     = fs_inst;
    assign fs_to_ds_bus.excp     = fs_adef;
    assign fs_to_ds_bus.excp_num = fs_adef ? cpu_pkg::ecode_adef : '0;

endmodule

`default_nettype wire

/* design/id_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     fs_to_ds_valid,
    input  wire cpu_pkg::fs_to_ds_t fs_to_ds_bus,
    input  wire                     es_allowin,
    input  wire                     excp_flush,
    input  wire                     ertn_flush,
    output logic                    ds_allowin,
    output cpu_pkg::br_bus_t        br_bus,
    output logic                    ds_to_es_valid,
    output cpu_pkg::ds_to_es_t      ds_to_es_bus
);

    logic               flush;
    logic               ds_valid;
    cpu_pkg::fs_to_ds_t ds_bus;
    logic [5:0]         opcode;
    logic [25:0]        offs26;
    logic               is_jump;
    cpu_pkg::word_t     jump_offset;

    assign flush = excp_flush | ertn_flush;

    assign ds_allowin = !ds_valid || es_allowin || flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    // b / bl decode.
    assign opcode = ds_bus.inst[31:26];
    assign offs26 = {ds_bus.inst[9:0], ds_bus.inst[25:10]};  // offs[25:16] sits in the low bits.

    // a faulting fetch carries no valid opcode.
    assign is_jump = !ds_bus.excp && (opcode == cpu_pkg::op_b || opcode == cpu_pkg::op_bl);

    assign jump_offset = {{4{offs26[25]}}, offs26, 2'b00};

    assign ds_to_es_valid = ds_valid && !flush;

    // redirect only when the jump actually leaves decode.
    assign br_bus.taken  = ds_to_es_valid && es_allowin && is_jump;
    assign br_bus.target = ds_bus.pc + jump_offset;

    assign ds_to_es_bus.pc       = ds_bus.pc;
    assign ds_to_es_bus.inst     = ds_bus.inst;
    assign ds_to_es_bus.excp     = ds_bus.excp;
    assign ds_to_es_bus.excp_num = ds_bus.excp_num;
    assign ds_to_es_bus.is_jump  = is_jump;

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     es_allowin,
    input  wire                     excp_flush,
    input  wire                     ertn_flush,
    input  wire cpu_pkg::word_t     era,
    input  wire cpu_pkg::word_t     eentry,
    input  wire                     load_en,
    input  wire cpu_pkg::mem_addr_t load_addr,
    input  wire cpu_pkg::word_t     load_data,
    output wire                     ds_to_es_valid,
    output cpu_pkg::ds_to_es_t      ds_to_es_bus
);

    wire                     ds_allowin;
    wire                     fs_to_ds_valid;
    wire cpu_pkg::fs_to_ds_t fs_to_ds_bus;
    wire cpu_pkg::br_bus_t   br_bus;
    wire                     inst_sram_en;
    wire cpu_pkg::word_t     inst_sram_addr;
    wire cpu_pkg::word_t     inst_sram_rdata;

    if_stage u_if (
        .clk             (clk),
        .reset           (reset),
        .ds_allowin      (ds_allowin),
        .br_bus          (br_bus),
        .excp_flush      (excp_flush),
        .ertn_flush      (ertn_flush),
        .era             (era),
        .eentry          (eentry),
        .inst_sram_rdata (inst_sram_rdata),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds_bus    (fs_to_ds_bus),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr)
    );

    inst_sram u_imem (
        .clk       (clk),
        .en        (inst_sram_en),
        .addr      (inst_sram_addr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (inst_sram_rdata)
    );

    id_stage u_id (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .excp_flush     (excp_flush),
        .ertn_flush     (ertn_flush),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus)
    );

endmodule

`default_nettype wire

/* dv/fetch_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_assert (
    input wire                     clk,
    input wire                     reset,
    input wire                     es_allowin,
    input wire                     excp_flush,
    input wire                     ertn_flush,
    input wire                     ds_to_es_valid,
    input wire cpu_pkg::ds_to_es_t ds_to_es_bus,
    input wire cpu_pkg::br_bus_t   br_bus
);

    logic flush;

    assign flush = excp_flush | ertn_flush;

    // a stalled decode keeps its entry.
    hold_bus: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> $stable(ds_to_es_bus))
        else $error("decode bus changed while stalled");

    hold_valid: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> ds_to_es_valid || flush)
        else $error("decode entry dropped while stalled");

    // the slot behind a taken jump comes in as a no-op.
    taken_shadow: assert property (@(posedge clk) disable iff (reset)
        br_bus.taken |=> flush
            || (ds_to_es_valid && ds_to_es_bus.inst == cpu_pkg::nop_inst
                && ds_to_es_bus.pc == $past(ds_to_es_bus.pc) + 32'd4))
        else $error("wrong-path slot behind a jump is not a no-op");

    flush_after: assert property (@(posedge clk) disable iff (reset)
        flush |=> !ds_to_es_valid)
        else $error("decode valid in the cycle after a flush");

endmodule

bind id_stage fetch_assert u_fetch_assert (
    .clk            (clk),
    .reset          (reset),
    .es_allowin     (es_allowin),
    .excp_flush     (excp_flush),
    .ertn_flush     (ertn_flush),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es_bus   (ds_to_es_bus),
    .br_bus         (br_bus)
);

`default_nettype wire

/* dv/fetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

    localparam int clk_period      = 40;
    localparam int drive_delay     = 2;
    localparam int reset_cycles    = 4;
    localparam int stim_cycles     = 1600;
    localparam int full_rate_cycles = 200;  // no back-pressure at the start.
    localparam int min_checked     = 600;
    localparam int watchdog_cycles =
        cpu_pkg::inst_mem_words + reset_cycles + stim_cycles * 4 + 200;

    logic                clk;
    logic                reset;
    logic                es_allowin;
    logic                excp_flush;
    logic                ertn_flush;
    cpu_pkg::word_t      era;
    cpu_pkg::word_t      eentry;
    logic                load_en;
    cpu_pkg::mem_addr_t  load_addr;
    cpu_pkg::word_t      load_data;
    logic                ds_to_es_valid;
    cpu_pkg::ds_to_es_t  ds_to_es_bus;

    cpu_pkg::word_t image [cpu_pkg::inst_mem_words];  // program as loaded into the sram.

    integer         seed;
    int             n_checked;
    int             n_jumps;
    int             n_shadow;
    int             n_adef;
    int             n_flushes;
    cpu_pkg::word_t exp_pc;
    logic           exp_shadow;     // next entry is the wrong-path slot behind a jump.
    cpu_pkg::word_t shadow_target;

    fetch_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .es_allowin     (es_allowin),
        .excp_flush     (excp_flush),
        .ertn_flush     (ertn_flush),
        .era            (era),
        .eentry         (eentry),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_ecode(input string name, input cpu_pkg::ecode_t got,
                               input cpu_pkg::ecode_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // add.w with register fields taken from the word index.
    function automatic cpu_pkg::word_t filler_word(input int idx);
        logic [14:0] regs;
        regs = 15'(idx) ^ 15'(idx << 5);
        return 32'h0010_0000 | {17'd0, regs};
    endfunction

    function automatic cpu_pkg::word_t jump_word(input logic [5:0] op, input int words);
        logic [25:0] offs;
        offs = 26'(words);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic place_jump(input int from, input int to, input logic [5:0] op);
        image[from] = jump_word(op, to - from);
    endtask

    task automatic build_program();
        for (int i = 0; i < cpu_pkg::inst_mem_words; i++) begin
            image[i] = filler_word(i);
        end
        place_jump(8, 24, cpu_pkg::op_b);
        place_jump(30, 60, cpu_pkg::op_bl);   // lands on another jump.
        place_jump(60, 100, cpu_pkg::op_b);
        place_jump(110, 40, cpu_pkg::op_b);   // backward loop.
        place_jump(260, 262, cpu_pkg::op_b);  // target right after the shadow slot.
        place_jump(390, 8, cpu_pkg::op_b);
        place_jump(520, 700, cpu_pkg::op_bl);
        place_jump(710, 515, cpu_pkg::op_b);
    endtask

    // offs26 is in words, sign extended.
    function automatic cpu_pkg::word_t jump_target(input cpu_pkg::word_t pc,
                                                   input cpu_pkg::word_t inst);
        int words;
        words = int'($signed({inst[9:0], inst[25:10]}));
        return pc + cpu_pkg::word_t'(words * 4);
    endfunction

    // expected decode output for the entry at pc.
    function automatic cpu_pkg::ds_to_es_t ref_entry(input cpu_pkg::word_t pc,
                                                     input logic shadow);
        cpu_pkg::ds_to_es_t e;
        logic [5:0]         op;
        e.pc       = pc;
        e.excp     = pc[1:0] != 2'b00;
        e.excp_num = e.excp ? cpu_pkg::ecode_adef : 16'h0000;
        e.inst     = shadow ? cpu_pkg::nop_inst : image[pc[11:2]];
        op         = e.inst[31:26];
        e.is_jump  = !e.excp && (op == cpu_pkg::op_b || op == cpu_pkg::op_bl);
        return e;
    endfunction

    task automatic advance_model(input cpu_pkg::ds_to_es_t e);
        if (exp_shadow) begin
            exp_pc     = shadow_target;
            exp_shadow = 1'b0;
        end else if (e.is_jump) begin
            shadow_target = jump_target(e.pc, e.inst);
            exp_shadow    = 1'b1;
            exp_pc        = e.pc + 32'd4;
        end else begin
            exp_pc = e.pc + 32'd4;
        end
    endtask

    initial begin : compare
        cpu_pkg::ds_to_es_t exp_e;
        exp_pc        = cpu_pkg::reset_vector;
        exp_shadow    = 1'b0;
        shadow_target = '0;
        n_checked     = 0;
        n_jumps       = 0;
        n_shadow      = 0;
        n_adef        = 0;
        n_flushes     = 0;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (excp_flush || ertn_flush) begin
                check_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
                exp_pc     = excp_flush ? eentry : era;
                exp_shadow = 1'b0;
                n_flushes++;
            end else if (ds_to_es_valid && es_allowin) begin
                exp_e = ref_entry(exp_pc, exp_shadow);
                check_word("ds_to_es_bus.pc", ds_to_es_bus.pc, exp_e.pc);
                check_word("ds_to_es_bus.inst", ds_to_es_bus.inst, exp_e.inst);
                check_bit("ds_to_es_bus.excp", ds_to_es_bus.excp, exp_e.excp);
                check_ecode("ds_to_es_bus.excp_num", ds_to_es_bus.excp_num, exp_e.excp_num);
                check_bit("ds_to_es_bus.is_jump", ds_to_es_bus.is_jump, exp_e.is_jump);
                n_checked++;
                if (exp_e.is_jump) n_jumps++;
                if (exp_shadow) n_shadow++;
                if (exp_e.excp) n_adef++;
                advance_model(exp_e);
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        seed       = 35301;
        reset      = 1'b1;
        es_allowin = 1'b0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        era        = '0;
        eentry     = '0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        build_program();
        // reset spans the program load and then four more cycles.
        for (int i = 0; i < cpu_pkg::inst_mem_words; i++) begin
            @(posedge clk);
            #(drive_delay);
            load_en   = 1'b1;
            load_addr = cpu_pkg::mem_addr_t'(i);
            load_data = image[i];
        end
        repeat (reset_cycles) begin
            @(posedge clk);
            #(drive_delay);
            load_en = 1'b0;
        end
        reset = 1'b0;
        for (int cyc = 0; cyc < stim_cycles; cyc++) begin
            @(posedge clk);
            #(drive_delay);
            rnd        = $random(seed);
            es_allowin = (cyc < full_rate_cycles) ? 1'b1 : (rnd[1:0] != 2'b00);
            excp_flush = 1'b0;
            ertn_flush = 1'b0;
            case (cyc)
                350: begin
                    excp_flush = 1'b1;
                    eentry     = 32'h1c00_0800;
                end
                650: begin
                    ertn_flush = 1'b1;
                    era        = 32'h1c00_0400;
                end
                950: begin
                    excp_flush = 1'b1;
                    eentry     = 32'h1c00_0602;  // misaligned, every fetch faults.
                end
                1200: begin
                    ertn_flush = 1'b1;
                    era        = 32'h1c00_0020;
                end
                1400: begin
                    excp_flush = 1'b1;
                    eentry     = 32'h1c00_0fe0;  // runs past the last word.
                end
                default: ;
            endcase
        end
        repeat (8) begin
            @(posedge clk);
            #(drive_delay);
            es_allowin = 1'b1;
            excp_flush = 1'b0;
            ertn_flush = 1'b0;
        end
        if (n_checked < min_checked || n_jumps == 0 || n_shadow == 0 || n_adef == 0
            || n_flushes != 5) begin
            abort_run($sformatf("too little was exercised: %0d results, %0d jumps, %0d adef",
                                n_checked, n_jumps, n_adef));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("the run did not reach its end before the watchdog expired");
    end

endmodule

`default_nettype wire

/* sources.f */
design/cpu_pkg.sv
design/inst_sram.sv
design/if_stage.sv
design/id_stage.sv
design/fetch_top.sv
dv/fetch_assert.sv
dv/fetch_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module fetch_tb -f sources.f -o fetch_sim
	@out="$$(./obj_dir/fetch_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir
